//--- filelist.f
+incdir+hw
hw/snd_pkg.sv
hw/snd_cen.sv
hw/snd_bus_decode.sv
hw/snd_ram.sv
hw/snd_din_mux.sv
hw/adpcm_voice.sv
hw/snd_mixer.sv
hw/snd_top.sv
sim/snd_rom_model.sv
sim/snd_tb.sv

//--- Bender.yml
package:
  name: snd_board

sources:
  - include_dirs:
      - hw
    files:
      - hw/snd_pkg.sv
      - hw/snd_cen.sv
      - hw/snd_bus_decode.sv
      - hw/snd_ram.sv
      - hw/snd_din_mux.sv
      - hw/adpcm_voice.sv
      - hw/snd_mixer.sv
      - hw/snd_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/snd_rom_model.sv
      - sim/snd_tb.sv

//--- sim/snd_tb.sv
// Sound board testbench with bus tasks, reference ADPCM decoder and checks
`timescale 1ns/1ps
`default_nettype none
`include "snd_params.svh"

module snd_tb import snd_pkg::*; ();

    localparam int NIBBLES    = 2 * `ADPCM_PHRASE_BYTES;
    localparam int PHRASE_CYC = NIBBLES * `ADPCM_DIV_SLOW * `SND_CEN_M;
    localparam int BUS_CYC    = 5 * 250;                    // Bus ops with idle gap
    localparam int LIMIT      = 2 * (BUS_CYC + 3 * PHRASE_CYC);

    localparam int STEPS [0:48] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279,
        307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963,
        1060, 1166, 1282, 1411, 1552
    };

    logic clk = 1'b0;
    logic rst;
    cpu_addr_t cpu_addr;
    byte_t cpu_dout, cpu_din, snd_latch0, snd_latch1, fm_dout, fm_din;
    logic mreq_n, wr_n, enable_fm, enable_adpcm, fm_sample;
    rom_addr_t rom_addr;
    logic rom_cs, fm_cs, fm_wr_n, fm_a0, adpcm_ok, adpcm_strobe, sample;
    byte_t rom_data, adpcm_data;
    adpcm_addr_t adpcm_addr;
    sample_t fm_left, fm_right, left, right;

    // Expected values and check enables
    logic chk_din = 0, chk_rom = 0, chk_fm = 0, chk_mix = 0, chk_pcm = 0;
    byte_t exp_din, exp_fm_din;
    logic exp_fm_a0, bank_ref;
    rom_addr_t exp_rom;
    sample_t exp_l, exp_r, exp_pcm;
    int errors = 0, checks = 0, tests = 0, cycles = 0;
    int ref_snd, ref_idx, ref_nib, diff, step;
    adpcm_addr_t ref_base;
    byte_t ref_byte;
    logic [3:0] ref_n;

    always #20 clk = ~clk;

    snd_top snd_top_i (
        .clk(clk), .rst(rst), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .mreq_n(mreq_n), .wr_n(wr_n), .cpu_din(cpu_din),
        .snd_latch0(snd_latch0), .snd_latch1(snd_latch1),
        .enable_fm(enable_fm), .enable_adpcm(enable_adpcm),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data),
        .adpcm_addr(adpcm_addr), .adpcm_data(adpcm_data), .adpcm_ok(adpcm_ok),
        .fm_cs(fm_cs), .fm_wr_n(fm_wr_n), .fm_a0(fm_a0), .fm_din(fm_din),
        .fm_dout(fm_dout), .fm_left(fm_left), .fm_right(fm_right),
        .fm_sample(fm_sample), .adpcm_strobe(adpcm_strobe),
        .left(left), .right(right), .sample(sample)
    );

    snd_rom_model rom_model_i (
        .clk(clk), .rst(rst), .rom_addr(rom_addr), .rom_data(rom_data),
        .adpcm_addr(adpcm_addr), .adpcm_data(adpcm_data), .adpcm_ok(adpcm_ok)
    );

    function automatic byte_t prog_byte(input rom_addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    function automatic byte_t pcm_byte(input adpcm_addr_t a);
        return (a[7:0] * 8'd37) ^ a[15:8] ^ {6'd0, a[17:16]};
    endfunction

    function automatic sample_t mix_expect(input logic en_fm, input logic en_pcm,
                                           input sample_t fm, input int pcm);
        sample_t t;
        t = '0;
        if (en_fm) t = fm >>> 1;            // Halved, sign kept
        if (en_pcm) t = t + sample_t'(pcm * 8);
        return t;
    endfunction

    din_ok: assert property (@(posedge clk) disable iff (rst) chk_din |-> cpu_din == exp_din)
        else begin
            errors++;
            $display("[ERROR] %0t cpu_din %h, expected %h", $time, cpu_din, exp_din);
        end

    rom_ok: assert property (@(posedge clk) disable iff (rst)
        chk_rom |-> rom_cs && rom_addr == exp_rom)
        else begin
            errors++;
            $display("[ERROR] %0t rom_addr %h cs %b, expected %h", $time, rom_addr, rom_cs, exp_rom);
        end

    fm_ok: assert property (@(posedge clk) disable iff (rst)
        chk_fm |-> fm_cs && !fm_wr_n && fm_din == exp_fm_din && fm_a0 == exp_fm_a0)
        else begin
            errors++;
            $display("[ERROR] %0t FM write cs %b din %h a0 %b", $time, fm_cs, fm_din, fm_a0);
        end

    sample_ok: assert property (@(posedge clk) disable iff (rst) sample == fm_sample)
        else begin
            errors++;
            $display("[ERROR] %0t sample %b, expected %b", $time, sample, fm_sample);
        end

    pcm_ok: assert property (@(posedge clk) disable iff (rst)
        (chk_pcm && adpcm_strobe) |=> left == exp_pcm && right == exp_pcm)
        else begin
            errors++;
            $display("[ERROR] %0t ADPCM out %h/%h, expected %h", $time, left, right, exp_pcm);
        end

    mix_ok: assert property (@(posedge clk) disable iff (rst)
        chk_mix |=> left == exp_l && right == exp_r)
        else begin
            errors++;
            $display("[ERROR] %0t mixer %h/%h, expected %h/%h", $time, left, right, exp_l, exp_r);
        end

    // Reference decoder steps on each strobe
    always @(posedge clk) begin
        if (!rst && adpcm_strobe) begin
            ref_byte = pcm_byte(ref_base + adpcm_addr_t'(ref_nib / 2));
            ref_n    = ref_nib[0] ? ref_byte[3:0] : ref_byte[7:4];
            step     = STEPS[ref_idx];
            diff     = step / 8;
            if (ref_n[2]) diff += step;
            if (ref_n[1]) diff += step / 2;
            if (ref_n[0]) diff += step / 4;
            ref_snd  = ref_n[3] ? ref_snd - diff : ref_snd + diff;
            if (ref_snd > 2047) ref_snd = 2047;
            if (ref_snd < -2048) ref_snd = -2048;
            ref_idx  = ref_idx + (ref_n[2] ? 2 * ref_n[1:0] + 2 : -1);
            if (ref_idx < 0) ref_idx = 0;
            if (ref_idx > 48) ref_idx = 48;
            ref_nib++;
            exp_pcm  = mix_expect(1'b0, 1'b1, '0, ref_snd);
            checks++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run went past %0d cycles", LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic bus_write(input cpu_addr_t a, input byte_t d, input logic fm_too);
        @(negedge clk);
        cpu_addr = a;
        cpu_dout = d;
        mreq_n   = 1'b0;
        wr_n     = 1'b0;
        chk_fm   = fm_too;
        repeat (4) @(posedge clk);
        @(negedge clk);
        mreq_n = 1'b1;
        wr_n   = 1'b1;
        chk_fm = 1'b0;
    endtask

    task automatic bus_read(input cpu_addr_t a, input byte_t d, input logic rom_too);
        @(negedge clk);
        cpu_addr = a;
        mreq_n   = 1'b0;
        wr_n     = 1'b1;
        repeat (3) @(posedge clk);       // Data valid 3 clocks after the address
        @(negedge clk);
        exp_din = d;
        chk_din = 1'b1;
        chk_rom = rom_too;
        checks++;
        @(posedge clk);
        @(negedge clk);
        chk_din = 1'b0;
        chk_rom = 1'b0;
        mreq_n  = 1'b1;
    endtask

    task automatic rom_read(input cpu_addr_t a);
        exp_rom = a[15] ? {1'b1, bank_ref, a[13:0]} : {1'b0, a[14:0]};
        bus_read(a, prog_byte(exp_rom), 1'b1);
    endtask

    task automatic play_phrase(input logic fast, input logic stop_early);
        logic [6:0] n;
        n = 7'($urandom);
        bus_write(16'hf006, {7'd0, fast}, 1'b0);
        ref_base = {1'b0, n, 10'd0};
        ref_snd  = 0;
        ref_idx  = 0;
        ref_nib  = 0;
        bus_write(16'hf002, {1'b1, n}, 1'b0);
        bus_read(16'hf002, 8'h01, 1'b0);
        while (ref_nib < (stop_early ? 4 : NIBBLES)) @(posedge clk);
        if (stop_early) begin
            bus_write(16'hf002, 8'h00, 1'b0);
            ref_snd = 0;
        end
        bus_read(16'hf002, 8'h00, 1'b0);
    endtask

    initial begin
        cpu_addr     = '0;
        cpu_dout     = '0;
        mreq_n       = 1'b1;
        wr_n         = 1'b1;
        snd_latch0   = '0;
        snd_latch1   = '0;
        enable_fm    = 1'b0;
        enable_adpcm = 1'b0;
        fm_dout      = '0;
        fm_left      = '0;
        fm_right     = '0;
        fm_sample    = 1'b0;
        bank_ref     = 1'b0;
        rst          = 1'b1;
        void'($urandom(32'h4574));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int b = 0; b < 2; b++) begin
            bus_write(16'hf004, 8'(b), 1'b0);
            bank_ref = b[0];
            for (int i = 0; i < 10; i++) begin
                rom_read(cpu_addr_t'($urandom) & 16'h7fff);
                rom_read(16'h8000 | (cpu_addr_t'($urandom) & 16'h3fff));
            end
        end
        tests++;
        $display("ROM mapping finished, errors %0d", errors);

        for (int i = 0; i < 20; i++) begin
            cpu_addr_t a;
            byte_t d;
            a = 16'hd000 | (cpu_addr_t'($urandom) & 16'h07ff);
            d = byte_t'($urandom);
            bus_write(a, d, 1'b0);
            bus_read(a, d, 1'b0);
        end
        tests++;
        $display("RAM finished, errors %0d", errors);

        for (int i = 0; i < 3; i++) begin
            snd_latch0 = byte_t'($urandom);
            snd_latch1 = byte_t'($urandom);
            fm_dout    = byte_t'($urandom);
            bus_read(16'hf008, snd_latch0, 1'b0);
            bus_read(16'hf00a, snd_latch1, 1'b0);
            bus_read(16'hf000, fm_dout, 1'b0);
            bus_read(16'hf00c, 8'hff, 1'b0);  // Unmapped registers
            bus_read(16'hf00e, 8'hff, 1'b0);
        end
        tests++;
        $display("Latches and unmapped space finished, errors %0d", errors);

        for (int i = 0; i < 8; i++) begin
            exp_fm_a0  = i[0];
            exp_fm_din = byte_t'($urandom);
            checks++;
            bus_write({15'h7800, exp_fm_a0}, exp_fm_din, 1'b1);
        end
        tests++;
        $display("FM register path finished, errors %0d", errors);

        // Full phrase last so the idle voice holds a nonzero sample
        enable_adpcm = 1'b1;
        chk_pcm      = 1'b1;
        play_phrase(1'b0, 1'b1);
        play_phrase(1'b0, 1'b0);
        play_phrase(1'b1, 1'b0);
        chk_pcm = 1'b0;
        tests++;
        $display("ADPCM playback finished, errors %0d", errors);

        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            enable_fm    = i[0];
            enable_adpcm = i[1];
            fm_left      = sample_t'($urandom);
            fm_right     = sample_t'($urandom);
            fm_sample    = 1'($urandom);
            exp_l        = mix_expect(enable_fm, enable_adpcm, fm_left, ref_snd);
            exp_r        = mix_expect(enable_fm, enable_adpcm, fm_right, ref_snd);
            chk_mix      = 1'b1;
            checks++;
            @(negedge clk);
            chk_mix = 1'b0;
        end
        tests++;
        $display("Mixer enables finished, errors %0d", errors);

        repeat (2) @(posedge clk);
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/snd_rom_model.sv
// Program ROM and ADPCM sample ROM models with address-derived contents
`timescale 1ns/1ps
`default_nettype none

module snd_rom_model import snd_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire rom_addr_t rom_addr,
    output byte_t       rom_data,
    input  wire adpcm_addr_t adpcm_addr,
    output byte_t       adpcm_data,
    output logic        adpcm_ok
);

    adpcm_addr_t last_addr;
    logic [2:0]  wait_cnt;

    // Program ROM answers one clock after the address
    always_ff @(posedge clk) begin
        rom_data <= rom_addr[7:0] ^ rom_addr[15:8] ^ 8'h5a;
    end

    // Sample ROM latency of 0 to 3 clocks, chosen by the low address bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_addr <= '0;
            wait_cnt  <= '0;
        end else if (adpcm_addr != last_addr) begin
            last_addr <= adpcm_addr;
            wait_cnt  <= '0;
        end else if (wait_cnt != 3'd7) begin
            wait_cnt <= wait_cnt + 3'd1;
        end
    end

    assign adpcm_ok   = (adpcm_addr == last_addr) && (wait_cnt >= {1'b0, last_addr[1:0]});
    assign adpcm_data = (adpcm_addr[7:0] * 8'd37) ^ adpcm_addr[15:8] ^ {6'd0, adpcm_addr[17:16]};

endmodule

`default_nettype wire

//--- hw/snd_top.sv
// Sound board top level with decoder, RAM, ADPCM voice, read mux and mixer
`timescale 1ns/1ps
`default_nettype none

module snd_top import snd_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire cpu_addr_t   cpu_addr,
    input  wire byte_t       cpu_dout,
    input  wire              mreq_n,
    input  wire              wr_n,
    output byte_t            cpu_din,
    input  wire byte_t       snd_latch0,
    input  wire byte_t       snd_latch1,
    input  wire              enable_fm,
    input  wire              enable_adpcm,
    output rom_addr_t        rom_addr,
    output logic             rom_cs,
    input  wire byte_t       rom_data,
    output adpcm_addr_t      adpcm_addr,
    input  wire byte_t       adpcm_data,
    input  wire              adpcm_ok,
    output logic             fm_cs,
    output logic             fm_wr_n,
    output logic             fm_a0,
    output byte_t            fm_din,
    input  wire byte_t       fm_dout,
    input  wire sample_t     fm_left,
    input  wire sample_t     fm_right,
    input  wire              fm_sample,
    output logic             adpcm_strobe,
    output sample_t          left,
    output sample_t          right,
    output logic             sample
);

    logic       ram_cs, ram_we, oki_cs, oki_we;
    logic       latch0_cs, latch1_cs, rate_fast, cen_oki;
    byte_t      ram_q, oki_dout;
    adpcm_snd_t adpcm_snd;

    // FM chip hangs straight off the bus
    assign fm_wr_n = wr_n;
    assign fm_a0   = cpu_addr[0];
    assign fm_din  = cpu_dout;
    assign sample  = fm_sample;

    snd_cen u_cen (.clk(clk), .rst(rst), .cen(cen_oki));

    snd_bus_decode u_decode (
        .clk       (clk),       .rst       (rst),
        .cpu_addr  (cpu_addr),  .cpu_dout  (cpu_dout),
        .mreq_n    (mreq_n),    .wr_n      (wr_n),
        .rom_addr  (rom_addr),  .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),    .ram_we    (ram_we),
        .fm_cs     (fm_cs),     .oki_cs    (oki_cs),
        .oki_we    (oki_we),    .latch0_cs (latch0_cs),
        .latch1_cs (latch1_cs), .rate_fast (rate_fast)
    );

    snd_ram u_ram (
        .clk (clk), .addr (cpu_addr[10:0]), .din (cpu_dout), .we (ram_we), .q (ram_q)
    );

    snd_din_mux u_din_mux (
        .clk        (clk),        .rst        (rst),
        .rom_cs     (rom_cs),     .ram_cs     (ram_cs),
        .fm_cs      (fm_cs),      .oki_cs     (oki_cs),
        .latch0_cs  (latch0_cs),  .latch1_cs  (latch1_cs),
        .snd_latch0 (snd_latch0), .snd_latch1 (snd_latch1),
        .fm_dout    (fm_dout),    .oki_dout   (oki_dout),
        .ram_q      (ram_q),      .rom_data   (rom_data),
        .cpu_din    (cpu_din)
    );

    adpcm_voice u_voice (
        .clk        (clk),        .rst        (rst),
        .cen        (cen_oki),    .rate_fast  (rate_fast),
        .we         (oki_we),     .din        (cpu_dout),
        .dout       (oki_dout),   .adpcm_addr (adpcm_addr),
        .adpcm_data (adpcm_data), .adpcm_ok   (adpcm_ok),
        .sound      (adpcm_snd),  .strobe     (adpcm_strobe)
    );

    snd_mixer u_mixer (
        .clk          (clk),          .rst       (rst),
        .enable_fm    (enable_fm),    .enable_adpcm (enable_adpcm),
        .fm_left      (fm_left),      .fm_right  (fm_right),
        .adpcm_snd    (adpcm_snd),    .left      (left),
        .right        (right)
    );

endmodule

`default_nettype wire

//--- hw/snd_mixer.sv
// Registered FM plus ADPCM mixer with an enable per source
`timescale 1ns/1ps
`default_nettype none

module snd_mixer import snd_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          enable_fm,
    input  wire          enable_adpcm,
    input  wire sample_t fm_left,
    input  wire sample_t fm_right,
    input  wire adpcm_snd_t adpcm_snd,
    output sample_t      left,
    output sample_t      right
);

    function automatic sample_t mix(input logic en_fm, input logic en_adpcm,
                                    input sample_t fm, input adpcm_snd_t pcm);
        sample_t fm_term;
        sample_t pcm_term;
        fm_term  = en_fm ? sample_t'({fm[15], fm[15:1]}) : '0;           // Half scale
        pcm_term = en_adpcm ? sample_t'({pcm[11], pcm, 3'd0}) : '0;      // 12 to 16 bits
        return fm_term + pcm_term;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left  <= '0;
            right <= '0;
        end else begin
            left  <= mix(enable_fm, enable_adpcm, fm_left, adpcm_snd);
            right <= mix(enable_fm, enable_adpcm, fm_right, adpcm_snd);
        end
    end

endmodule

`default_nettype wire

//--- hw/adpcm_voice.sv
// Single-voice ADPCM phrase player with sample ROM fetch and nibble decoder
`timescale 1ns/1ps
`default_nettype none
`include "snd_params.svh"

module adpcm_voice import snd_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         cen,
    input  wire         rate_fast,
    input  wire         we,
    input  wire byte_t  din,
    output byte_t       dout,
    output adpcm_addr_t adpcm_addr,
    input  wire byte_t  adpcm_data,
    input  wire         adpcm_ok,
    output adpcm_snd_t  sound,
    output logic        strobe
);

    // Standard 49-entry ADPCM step sizes
    localparam logic [10:0] STEP_TAB [0:48] = '{
          16,   17,   19,   21,   23,   25,   28,   31,   34,   37,
          41,   45,   50,   55,   60,   66,   73,   80,   88,   97,
         107,  118,  130,  143,  157,  173,  190,  209,  230,  253,
         279,  307,  337,  371,  408,  449,  494,  544,  598,  658,
         724,  796,  876,  963, 1060, 1166, 1282, 1411, 1552
    };

    adpcm_state_t state;
    byte_t        rom_byte;
    logic         we_l;
    logic [5:0]   step_idx;
    logic [3:0]   div_cnt;
    logic [$clog2(`ADPCM_PHRASE_BYTES)-1:0] byte_cnt;

    logic              cmd_edge, nib_done, decoding;
    logic [3:0]        div_max;
    logic [3:0]        nibble;
    logic [10:0]       step;
    logic [12:0]       delta;
    logic signed [13:0] sum;
    adpcm_snd_t        sound_next;
    logic signed [6:0] idx_sum;
    logic [5:0]        idx_next;

    assign cmd_edge = we & ~we_l;
    assign decoding = (state == DECODE_HI) || (state == DECODE_LO);
    assign div_max  = rate_fast ? 4'(`ADPCM_DIV_FAST - 1) : 4'(`ADPCM_DIV_SLOW - 1);
    assign nib_done = decoding && cen && (div_cnt == div_max);
    assign nibble   = (state == DECODE_HI) ? rom_byte[7:4] : rom_byte[3:0];
    assign dout     = {7'd0, state != IDLE}; // Busy flag

    always_comb begin
        step  = STEP_TAB[step_idx];
        delta = 13'(step >> 3);
        if (nibble[2]) delta = delta + 13'(step);
        if (nibble[1]) delta = delta + 13'(step >> 1);
        if (nibble[0]) delta = delta + 13'(step >> 2);
        sum = nibble[3] ? $signed({{2{sound[11]}}, sound}) - $signed({1'b0, delta})
                        : $signed({{2{sound[11]}}, sound}) + $signed({1'b0, delta});
        if (sum > 14'sd2047)       sound_next = 12'sd2047;  // Clamp to 12 bits
        else if (sum < -14'sd2048) sound_next = -12'sd2048;
        else                       sound_next = sum[11:0];
        idx_sum = $signed({1'b0, step_idx}) +
                  (nibble[2] ? 7'sd2 + $signed({4'd0, nibble[1:0], 1'b0}) : -7'sd1);
        if (idx_sum < 0)            idx_next = 6'd0;
        else if (idx_sum > 7'sd48)  idx_next = 6'd48;
        else                        idx_next = idx_sum[5:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            we_l       <= 1'b0;
            adpcm_addr <= '0;
            byte_cnt   <= '0;
            div_cnt    <= '0;
            step_idx   <= '0;
            sound      <= '0;
            strobe     <= 1'b0;
        end else begin
            we_l   <= we;
            strobe <= nib_done;
            if (cmd_edge && din[7]) begin // Start phrase n at n*1024
                state      <= FETCH;
                adpcm_addr <= {1'b0, din[6:0], 10'd0};
                byte_cnt   <= '0;
                step_idx   <= '0;
                sound      <= '0;
            end else if (cmd_edge && din == 8'd0) begin
                state <= IDLE;
                sound <= '0;
            end else begin
                case (state)
                    FETCH: state <= WAIT_ROM; // Let the ROM see the new address
                    WAIT_ROM: if (adpcm_ok) begin
                        state   <= DECODE_HI;
                        div_cnt <= '0;
                    end
                    DECODE_HI, DECODE_LO: if (cen) begin
                        div_cnt <= nib_done ? 4'd0 : div_cnt + 4'd1;
                        if (nib_done) begin
                            sound    <= sound_next;
                            step_idx <= idx_next;
                            if (state == DECODE_HI) begin
                                state <= DECODE_LO;
                            end else if (byte_cnt == ($bits(byte_cnt))'(`ADPCM_PHRASE_BYTES - 1)) begin
                                state <= IDLE;
                            end else begin
                                state      <= FETCH;
                                byte_cnt   <= byte_cnt + 1'b1;
                                adpcm_addr <= adpcm_addr + 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Byte register only loads from the ROM handshake
    always_ff @(posedge clk) begin
        if (state == WAIT_ROM && adpcm_ok) rom_byte <= adpcm_data;
    end

    step_idx_range: assert property (@(posedge clk) disable iff (rst)
        step_idx <= 6'd48);

    strobe_in_decode: assert property (@(posedge clk) disable iff (rst)
        strobe |-> $past(state) inside {DECODE_HI, DECODE_LO});

endmodule

`default_nettype wire

//--- hw/snd_din_mux.sv
// Two-stage registered read data mux back to the sound CPU
`timescale 1ns/1ps
`default_nettype none

module snd_din_mux import snd_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        rom_cs,
    input  wire        ram_cs,
    input  wire        fm_cs,
    input  wire        oki_cs,
    input  wire        latch0_cs,
    input  wire        latch1_cs,
    input  wire byte_t snd_latch0,
    input  wire byte_t snd_latch1,
    input  wire byte_t fm_dout,
    input  wire byte_t oki_dout,
    input  wire byte_t ram_q,
    input  wire byte_t rom_data,
    output byte_t      cpu_din
);

    byte_t cmd_q, dev_q, mem_q;
    logic  latch_sel, dev_sel, mem_sel;

    // First stage, one byte per group
    always_ff @(posedge clk) begin
        cmd_q <= latch0_cs ? snd_latch0 : snd_latch1;
        dev_q <= fm_cs ? fm_dout : oki_dout;
        mem_q <= ram_cs ? ram_q : rom_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latch_sel <= 1'b0;
            dev_sel   <= 1'b0;
            mem_sel   <= 1'b0;
            cpu_din   <= 8'hff;
        end else begin
            latch_sel <= latch0_cs | latch1_cs;
            dev_sel   <= fm_cs | oki_cs;
            mem_sel   <= ram_cs | rom_cs;
            if (dev_sel)        cpu_din <= dev_q; // Devices win
            else if (latch_sel) cpu_din <= cmd_q;
            else if (mem_sel)   cpu_din <= mem_q;
            else                cpu_din <= 8'hff; // Open bus
        end
    end

endmodule

`default_nettype wire

//--- hw/snd_ram.sv
// Sound CPU work RAM with synchronous read
`timescale 1ns/1ps
`default_nettype none
`include "snd_params.svh"

module snd_ram import snd_pkg::*; (
    input  wire                    clk,
    input  wire [`SND_RAM_AW-1:0]  addr,
    input  wire byte_t             din,
    input  wire                    we,
    output byte_t                  q
);

    byte_t mem [0:(1<<`SND_RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        q <= mem[addr]; // Old data on a write cycle
    end

endmodule

`default_nettype wire

//--- hw/snd_bus_decode.sv
// Sound CPU memory map decoder with bank and ADPCM rate registers
`timescale 1ns/1ps
`default_nettype none
`include "snd_params.svh"

module snd_bus_decode import snd_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire cpu_addr_t cpu_addr,
    input  wire byte_t     cpu_dout,
    input  wire       mreq_n,
    input  wire       wr_n,
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    output logic      ram_cs,
    output logic      ram_we,
    output logic      fm_cs,
    output logic      oki_cs,
    output logic      oki_we,
    output logic      latch0_cs,
    output logic      latch1_cs,
    output logic      rate_fast
);

    logic bank;
    logic bank_cs;
    logic rate_cs;
    logic wr;

    assign wr     = ~wr_n & ~mreq_n;
    assign ram_we = ram_cs & wr;
    assign oki_we = oki_cs & wr;

    always_comb begin
        rom_addr  = '0;
        rom_cs    = 1'b0;
        ram_cs    = 1'b0;
        fm_cs     = 1'b0;
        oki_cs    = 1'b0;
        bank_cs   = 1'b0;
        rate_cs   = 1'b0;
        latch0_cs = 1'b0;
        latch1_cs = 1'b0;
        if (!mreq_n) begin
            casez (cpu_addr[15:12])
                4'b0???: begin // Fixed half
                    rom_cs   = 1'b1;
                    rom_addr = {1'b0, cpu_addr[14:0]};
                end
                4'b10??: begin // Banked window
                    rom_cs   = 1'b1;
                    rom_addr = {1'b1, bank, cpu_addr[13:0]};
                end
                4'b1101: ram_cs = 1'b1;
                4'b1111: begin
                    case (cpu_addr[3:1])
                        3'd0: fm_cs     = 1'b1;
                        3'd1: oki_cs    = 1'b1;
                        3'd2: bank_cs   = 1'b1;
                        3'd3: rate_cs   = 1'b1;
                        3'd4: latch0_cs = 1'b1;
                        3'd5: latch1_cs = 1'b1;
                        default: ;     // Unmapped, reads FF
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank      <= 1'b0;
            rate_fast <= 1'b0; // Slow rate
        end else begin
            if (bank_cs && wr) bank <= cpu_dout[0];
            if (rate_cs && wr) rate_fast <= cpu_dout[0];
        end
    end

    one_chip_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, fm_cs, oki_cs, bank_cs, rate_cs, latch0_cs, latch1_cs}));

endmodule

`default_nettype wire

//--- hw/snd_cen.sv
// Fractional clock enable generator pacing the ADPCM voice
`timescale 1ns/1ps
`default_nettype none
`include "snd_params.svh"

module snd_cen import snd_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    output logic cen
);

    cen_acc_t acc;
    cen_acc_t acc_next;

    assign acc_next = acc + cen_acc_t'(`SND_CEN_N);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            cen <= 1'b0;
        end else begin
            if (acc_next >= cen_acc_t'(`SND_CEN_M)) begin
                acc <= acc_next - cen_acc_t'(`SND_CEN_M); // Keep the remainder
                cen <= 1'b1;
            end else begin
                acc <= acc_next;
                cen <= 1'b0;
            end
        end
    end

    // N/M is well under one half so pulses never touch
    cen_single_pulse: assert property (@(posedge clk) disable iff (rst)
        cen |=> !cen);

endmodule

`default_nettype wire

//--- hw/snd_pkg.sv
// Sound board shared types for bus, ROM, samples and the ADPCM state machine
`default_nettype none

package snd_pkg;

    typedef logic [15:0] cpu_addr_t;   // Sound CPU address
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] rom_addr_t;   // Program ROM, 64 KB with banking
    typedef logic [17:0] adpcm_addr_t; // Sample ROM, 256 KB

    typedef logic signed [11:0] adpcm_snd_t;
    typedef logic signed [15:0] sample_t;

    // Wide enough for SND_CEN_M plus SND_CEN_N
    typedef logic [6:0] cen_acc_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_ROM,
        DECODE_HI,
        DECODE_LO
    } adpcm_state_t;

endpackage

`default_nettype wire

//--- hw/snd_params.svh
// Sound board constants for memory map, clock enable and ADPCM phrase timing
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// Work RAM, 2 KB
`define SND_RAM_AW 11

// ADPCM clock enable fires N times every M clocks
`define SND_CEN_N 1
`define SND_CEN_M 48

// Fixed phrase length
`define ADPCM_PHRASE_BYTES 16

// Enables per nibble for each rate select
`define ADPCM_DIV_FAST 8
`define ADPCM_DIV_SLOW 10

`endif
